// ==== hdl/imul_msg_pkg.sv ====
/*
  imul message types
  request and response payloads carried over the val/rdy links
*/

package imul_msg_pkg;

  // --------------------------------------------------
  // request message
  // --------------------------------------------------

  // two's-complement operands with a in the upper half
  typedef struct packed {
    logic signed [31:0] a;
    logic signed [31:0] b;
  } mul_req_t;

  // --------------------------------------------------
  // response message
  // --------------------------------------------------

  // full-width signed product
  typedef struct packed {
    logic signed [63:0] result;
  } mul_resp_t;

endpackage

// ==== hdl/imul_ctrl_pkg.sv ====
/*
  imul control definitions
  FSM states, iteration count and queue sizing
*/

package imul_ctrl_pkg;

  // multiplier control states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } mul_state_e;

  // add/shift cycles per multiply and counter width
  localparam int MUL_ITERATIONS = 32;
  localparam int ITER_COUNT_W = 5;
  // cycles from the accepting edge until resp_val is seen high
  localparam int MUL_LATENCY = 33;

  // request queue sizing
  localparam int REQ_QUEUE_DEPTH = 2;
  localparam int REQ_PTR_W = $clog2(REQ_QUEUE_DEPTH);
  localparam int REQ_CNT_W = $clog2(REQ_QUEUE_DEPTH + 1);

endpackage

// ==== hdl/imul_req_queue.sv ====
/*
  imul request queue
  small in-order FIFO between the producer and the iterative multiplier
*/

`timescale 1ns/1ps

module imul_req_queue
  import imul_msg_pkg::*;
  import imul_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // producer side
  input  mul_req_t req_msg,
  input  logic     req_val,
  output logic     req_rdy,

  // multiplier side
  output mul_req_t q_msg,
  output logic     q_val,
  input  logic     q_rdy
);

  // --------------------------------------------------
  // storage and pointers
  // --------------------------------------------------

  // request payload slots
  mul_req_t entries [REQ_QUEUE_DEPTH];

  logic [REQ_PTR_W-1:0] wr_ptr;
  logic [REQ_PTR_W-1:0] rd_ptr;
  logic [REQ_CNT_W-1:0] count;

  logic push;
  logic pop;

  // full/empty come from the count alone
  assign req_rdy = (count != REQ_CNT_W'(REQ_QUEUE_DEPTH));
  assign q_val   = (count != '0);
  // head of queue
  assign q_msg   = entries[rd_ptr];

  assign push = req_val && req_rdy;
  assign pop  = q_val && q_rdy;

  // write the pushed request into the tail slot
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= req_msg;
    end
  end

  // --------------------------------------------------
  // pointer and occupancy update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // circular wrap at the last slot
      if (push) begin
        if (wr_ptr == REQ_PTR_W'(REQ_QUEUE_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == REQ_PTR_W'(REQ_QUEUE_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/imul_iter_ctrl.sv ====
/*
  imul iteration control
  IDLE/CALC/DONE FSM that steers the shift-add datapath
*/

`timescale 1ns/1ps

module imul_iter_ctrl
  import imul_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request handshake from the queue
  input  logic q_val,
  output logic q_rdy,

  // response handshake to the outside
  output logic resp_val,
  input  logic resp_rdy,

  // datapath steering
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);

  mul_state_e state;
  logic [ITER_COUNT_W-1:0] count;

  logic q_xfer;
  logic resp_xfer;
  logic last_iter;

  // handshake tests with rdy decoded from the state
  assign q_xfer    = q_val && (state == IDLE);
  assign resp_xfer = resp_rdy && (state == DONE);
  assign last_iter = (count == ITER_COUNT_W'(MUL_ITERATIONS - 1));

  // --------------------------------------------------
  // state and iteration counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          // start a new multiply on accept
          if (q_xfer) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // 32 shift-add edges counted 0..31
          if (last_iter) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold the result until the receiver takes it
          if (resp_xfer) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  always_comb begin
    q_rdy     = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    a_mux_sel = 1'b0;
    b_en      = 1'b0;
    b_mux_sel = 1'b0;
    case (state)
      IDLE: begin
        q_rdy = 1'b1;
        // load operands from the request on accept
        a_en  = q_xfer;
        b_en  = q_xfer;
      end
      CALC: begin
        // shift every cycle
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
      end
      DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        resp_val = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/imul_iter_dpath.sv ====
/*
  imul shift-add datapath
  signed 32x32 multiply as magnitudes with a final sign fix
*/

`timescale 1ns/1ps

module imul_iter_dpath
  import imul_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  mul_req_t  q_msg,

  // steering from the control FSM
  input  logic      a_en,
  input  logic      a_mux_sel,
  input  logic      b_en,
  input  logic      b_mux_sel,

  output mul_resp_t resp_msg
);

  // --------------------------------------------------
  // operand conditioning
  // --------------------------------------------------

  logic        sign_a;
  logic        sign_b;
  logic [31:0] mag_a;
  logic [31:0] mag_b;

  assign sign_a = q_msg.a[31];
  assign sign_b = q_msg.b[31];
  // two's-complement magnitude where the most negative value maps to 2^31
  assign mag_a  = sign_a ? (~q_msg.a + 32'd1) : q_msg.a;
  assign mag_b  = sign_b ? (~q_msg.b + 32'd1) : q_msg.b;

  // --------------------------------------------------
  // shift registers
  // --------------------------------------------------

  logic [63:0] a_reg;
  logic [31:0] b_reg;
  logic [63:0] a_mux_out;
  logic [31:0] b_mux_out;

  // select 0 loads from the request and select 1 shifts
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {32'd0, mag_a};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : mag_b;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
  end

  // --------------------------------------------------
  // accumulator and stored signs
  // --------------------------------------------------

  logic        sign_a_reg;
  logic        sign_b_reg;
  logic [63:0] result_reg;
  logic [63:0] result_next;

  // add the shifted multiplicand when the current multiplier bit is set
  assign result_next = b_reg[0] ? (result_reg + a_reg) : result_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      result_reg <= '0;
    end else if (b_en && !b_mux_sel) begin
      // new request captures the signs and clears the sum
      sign_a_reg <= sign_a;
      sign_b_reg <= sign_b;
      result_reg <= '0;
    end else if (b_en && b_mux_sel) begin
      result_reg <= result_next;
    end
  end

  // --------------------------------------------------
  // response
  // --------------------------------------------------

  logic neg_result;

  // negative product when exactly one operand was negative
  assign neg_result      = sign_a_reg ^ sign_b_reg;
  assign resp_msg.result = neg_result ? (~result_reg + 64'd1) : result_reg;

endmodule

// ==== hdl/imul_unit.sv ====
/*
  imul unit top level
  request queue in front of the iterative signed multiplier
*/

`timescale 1ns/1ps

module imul_unit
  import imul_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  mul_req_t  req_msg,
  input  logic      req_val,
  output logic      req_rdy,

  output mul_resp_t resp_msg,
  output logic      resp_val,
  input  logic      resp_rdy
);

  // queue to multiplier link
  mul_req_t q_msg;
  logic     q_val;
  logic     q_rdy;

  // control to datapath steering
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;

  // --------------------------------------------------
  // request queue
  // --------------------------------------------------

  imul_req_queue req_queue_i (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .q_msg   (q_msg),
    .q_val   (q_val),
    .q_rdy   (q_rdy)
  );

  // --------------------------------------------------
  // multiplier control and datapath
  // --------------------------------------------------

  imul_iter_ctrl iter_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .q_val     (q_val),
    .q_rdy     (q_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

  imul_iter_dpath iter_dpath_i (
    .clk       (clk),
    .reset     (reset),
    .q_msg     (q_msg),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .resp_msg  (resp_msg)
  );

endmodule

// ==== bench/imul_unit_sva.sv ====
/*
  imul unit assertions
  handshake, latency and queue occupancy properties bound into the top level
*/

`timescale 1ns/1ps

module imul_unit_sva
  import imul_msg_pkg::*;
  import imul_ctrl_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      req_val,
  input logic      req_rdy,
  input logic      q_val,
  input logic      q_rdy,
  input mul_resp_t resp_msg,
  input logic      resp_val,
  input logic      resp_rdy
);

  logic push;
  logic pop;
  logic [REQ_CNT_W-1:0] occupancy;

  assign push = req_val && req_rdy;
  assign pop  = q_val && q_rdy;

  // independent occupancy model of the request queue
  always_ff @(posedge clk) begin
    if (reset) begin
      occupancy <= '0;
    end else if (push && !pop) begin
      occupancy <= occupancy + 1'b1;
    end else if (pop && !push) begin
      occupancy <= occupancy - 1'b1;
    end
  end

  // --------------------------------------------------
  // properties
  // --------------------------------------------------

  // stalled response holds valid and payload
  resp_held: assert property (@(posedge clk) disable iff (reset)
      resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else $error("response changed while stalled by resp_rdy");

  // resp_val rises exactly MUL_LATENCY edges after each accept
  latency_after_accept: assert property (@(posedge clk) disable iff (reset)
      $past(q_val && q_rdy, MUL_LATENCY) |-> $rose(resp_val))
    else $error("resp_val did not rise MUL_LATENCY cycles after an accept");
  latency_before_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(resp_val) |-> $past(q_val && q_rdy, MUL_LATENCY))
    else $error("resp_val rose without an accept MUL_LATENCY cycles before");

  // no push into a full queue
  no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      !(push && occupancy == REQ_CNT_W'(REQ_QUEUE_DEPTH)))
    else $error("request queue accepted a request while full");

endmodule

bind imul_unit imul_unit_sva imul_unit_sva_i (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .q_val    (q_val),
  .q_rdy    (q_rdy),
  .resp_msg (resp_msg),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy)
);

// ==== bench/imul_unit_tb.sv ====
/*
  imul unit testbench
  directed tests against a signed product reference model
*/

`timescale 1ns/1ps

module imul_unit_tb
  import imul_msg_pkg::*;
  import imul_ctrl_pkg::*;
();

  // requests over all tests for the watchdog limit
  localparam int TOTAL_REQUESTS = 82;
  localparam int CLK_PERIOD = 10;

  logic      clk;
  logic      reset;
  mul_req_t  req_msg;
  logic      req_val;
  logic      req_rdy;
  mul_resp_t resp_msg;
  logic      resp_val;
  logic      resp_rdy;

  integer seed = 5185;

  // reference products in request order
  mul_resp_t expected_q [$];
  int        resp_count = 0;

  // values seen at the last clock edge
  logic      s_req_fire;
  logic      s_resp_fire;
  logic      s_req_rdy;
  logic      s_resp_val;
  mul_req_t  s_req_msg;
  mul_resp_t s_resp_msg;

  imul_unit imul_unit_i (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // failure reporting and compares
  // --------------------------------------------------

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic compare_resp(input string name, input mul_resp_t expected,
                              input mul_resp_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %0d (%h), got %0d (%h)", $time, name,
               expected.result, expected.result, actual.result, actual.result);
      stop_on_failure();
    end
  endtask

  // watchdog allows about 40 cycles per request plus margin
  initial begin
    repeat ((TOTAL_REQUESTS + 4) * 40) @(posedge clk);
    $display("timeout: the tests did not finish in %0d cycles", (TOTAL_REQUESTS + 4) * 40);
    stop_on_failure();
  end

  // --------------------------------------------------
  // reference model and stimulus helpers
  // --------------------------------------------------

  // full product of the sign-extended operands
  function automatic mul_resp_t signed_product(input mul_req_t req);
    mul_resp_t resp;
    longint    a_ext;
    longint    b_ext;
    a_ext = {{32{req.a[31]}}, req.a};
    b_ext = {{32{req.b[31]}}, req.b};
    resp.result = a_ext * b_ext;
    return resp;
  endfunction

  function automatic mul_req_t make_req(input logic signed [31:0] a,
                                        input logic signed [31:0] b);
    mul_req_t req;
    req.a = a;
    req.b = b;
    return req;
  endfunction

  function automatic mul_req_t random_req();
    mul_req_t req;
    req.a = $random(seed);
    req.b = $random(seed);
    return req;
  endfunction

  // sample at negedge then step to the edge and score transfers there
  task automatic clock_edge();
    mul_resp_t exp_resp;
    @(negedge clk);
    s_req_rdy   = req_rdy;
    s_resp_val  = resp_val;
    s_req_msg   = req_msg;
    s_resp_msg  = resp_msg;
    s_req_fire  = req_val && req_rdy;
    s_resp_fire = resp_val && resp_rdy;
    @(posedge clk);
    if (s_req_fire) begin
      expected_q.push_back(signed_product(s_req_msg));
    end
    if (s_resp_fire) begin
      if (expected_q.size() == 0) begin
        $display("at %0t a response arrived with no request pending", $time);
        stop_on_failure();
      end else begin
        exp_resp = expected_q.pop_front();
        compare_resp("resp_msg", exp_resp, s_resp_msg);
        resp_count++;
      end
    end
  endtask

  // one request into an empty unit with resp_val expected exactly 34 edges later
  task automatic multiply_once(input mul_req_t req);
    int n;
    req_msg  <= req;
    req_val  <= 1'b1;
    resp_rdy <= 1'b1;
    do begin
      clock_edge();
    end while (!s_req_fire);
    req_val <= 1'b0;
    for (n = 1; n <= MUL_LATENCY + 1; n++) begin
      clock_edge();
      compare_bit("resp_val", (n == MUL_LATENCY + 1), s_resp_val);
    end
  endtask

  // continuous random requests until every response is back
  task automatic send_stream(input int num_reqs, input bit random_rdy);
    int     sent;
    int     start_count;
    integer rnd;
    sent        = 0;
    start_count = resp_count;
    req_msg  <= random_req();
    req_val  <= 1'b1;
    resp_rdy <= 1'b1;
    while (resp_count - start_count < num_reqs) begin
      clock_edge();
      if (s_req_fire) begin
        sent++;
        if (sent < num_reqs) begin
          req_msg <= random_req();
        end else begin
          req_val <= 1'b0;
        end
      end
      if (random_rdy) begin
        rnd = $random(seed);
        resp_rdy <= rnd[0];
      end
    end
    req_val  <= 1'b0;
    resp_rdy <= 1'b1;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic check_reset_state();
    clock_edge();
    compare_bit("req_rdy", 1'b1, s_req_rdy);
    compare_bit("resp_val", 1'b0, s_resp_val);
  endtask

  task automatic corner_products();
    multiply_once(make_req(32'sd0, 32'sd12345));
    multiply_once(make_req(32'sd1, -32'sd1));
    multiply_once(make_req(-32'sd1, -32'sd1));
    multiply_once(make_req(32'sh7fffffff, 32'sh7fffffff));
    multiply_once(make_req(32'sh80000000, 32'sh80000000));
    multiply_once(make_req(32'sh80000000, 32'sd1));
    multiply_once(make_req(32'sd46341, -32'sd9876));
  endtask

  task automatic random_pairs();
    send_stream(40, 1'b0);
  endtask

  // stall the output, fill the unit, then drain and send two more
  task automatic back_pressure();
    int accepted;
    int start_count;
    accepted    = 0;
    start_count = resp_count;
    req_msg  <= random_req();
    req_val  <= 1'b1;
    resp_rdy <= 1'b0;
    repeat (2 * MUL_LATENCY) begin
      clock_edge();
      if (s_req_fire) begin
        accepted++;
        req_msg <= random_req();
      end
      // held response must match the oldest request throughout
      if (s_resp_val) begin
        compare_resp("resp_msg", expected_q[0], s_resp_msg);
      end
    end
    if (accepted != REQ_QUEUE_DEPTH + 1) begin
      $display("ERROR at %0t: accepted requests expected %0d, got %0d", $time,
               REQ_QUEUE_DEPTH + 1, accepted);
      stop_on_failure();
    end
    compare_bit("req_rdy", 1'b0, s_req_rdy);
    compare_bit("resp_val", 1'b1, s_resp_val);
    resp_rdy <= 1'b1;
    while (resp_count - start_count < REQ_QUEUE_DEPTH + 3) begin
      clock_edge();
      if (s_req_fire) begin
        accepted++;
        if (accepted == REQ_QUEUE_DEPTH + 3) begin
          req_val <= 1'b0;
        end else begin
          req_msg <= random_req();
        end
      end
    end
  endtask

  task automatic streaming();
    send_stream(30, 1'b1);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    reset    <= 1'b1;
    req_val  <= 1'b0;
    req_msg  <= '0;
    resp_rdy <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    check_reset_state();
    corner_products();
    random_pairs();
    back_pressure();
    streaming();
    // idle edges catch any stray response
    repeat (4) clock_edge();
    if (expected_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("%0d responses never arrived", expected_q.size());
      stop_on_failure();
    end
  end

endmodule

// ==== files.f ====
hdl/imul_msg_pkg.sv
hdl/imul_ctrl_pkg.sv
hdl/imul_req_queue.sv
hdl/imul_iter_ctrl.sv
hdl/imul_iter_dpath.sv
hdl/imul_unit.sv
bench/imul_unit_sva.sv
bench/imul_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the imul unit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=imul_unit_sim

verilator --binary --assert --top-module imul_unit_tb \
  -f files.f --Mdir obj_dir -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failed" "$log_file"; then
  exit 1
fi
exit 0
